/* src/adc_pkg.sv */
// Shared widths, sample and configuration types and register map for the ADC conditioning chain
package adc_pkg;

    localparam int n_channels = 4;
    localparam int data_width = 16;
    localparam int ch_width = 2;
    localparam int max_shift = 7;
    localparam int max_ratio = 16;
    localparam int addr_width = 5;

    // Field widths derived from the limits above
    localparam int shift_width = $clog2(max_shift + 1);
    localparam int ratio_width = $clog2(max_ratio + 1);

    typedef logic signed [data_width-1:0] data_t;

    typedef struct packed {
        data_t               data;
        logic [ch_width-1:0] channel;
    } sample_t;

    typedef struct packed {
        logic                                   shift_enable;
        data_t [n_channels-1:0]                 offset;
        logic  [n_channels-1:0][shift_width-1:0] shift;
    } cal_cfg_t;

    typedef struct packed {
        logic                   enable;
        data_t [n_channels-1:0] band_high;
        data_t [n_channels-1:0] band_low;
    } denoise_cfg_t;

    typedef struct packed {
        data_t high;
        data_t low;
        logic  latch;
        logic  clear;
    } cmp_cfg_t;

    // Register map, per-channel banks start at the base addresses
    localparam logic [addr_width-1:0] reg_control = 5'd0;
    localparam logic [addr_width-1:0] reg_ratio = 5'd1;
    localparam logic [addr_width-1:0] reg_clear = 5'd2;
    localparam logic [addr_width-1:0] reg_fast_high = 5'd4;
    localparam logic [addr_width-1:0] reg_fast_low = 5'd5;
    localparam logic [addr_width-1:0] reg_slow_high = 5'd6;
    localparam logic [addr_width-1:0] reg_slow_low = 5'd7;
    localparam logic [addr_width-1:0] reg_offset_base = 5'd8;
    localparam logic [addr_width-1:0] reg_shift_base = 5'd12;
    localparam logic [addr_width-1:0] reg_band_high_base = 5'd16;
    localparam logic [addr_width-1:0] reg_band_low_base = 5'd20;

endpackage

/* src/calibration.sv */
// Per-channel offset and right-shift calibration stage, one cycle from raw input to output
`timescale 1ns/100ps

module calibration
    import adc_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  sample_t  raw_sample,
    input  logic     raw_valid,
    input  cal_cfg_t cfg,
    output sample_t  cal_sample,
    output logic     cal_valid
);

    logic signed [data_width:0] sum;
    data_t                      saturated;
    data_t                      shifted;

    always_comb begin
        // One extra bit keeps the true sum for the overflow check
        sum = raw_sample.data + $signed(cfg.offset[raw_sample.channel]);
        if (sum[data_width] != sum[data_width-1]) begin
            // Clip to the nearest limit
            saturated = sum[data_width] ? {1'b1, {(data_width-1){1'b0}}}
                                        : {1'b0, {(data_width-1){1'b1}}};
        end else begin
            saturated = sum[data_width-1:0];
        end
        if (cfg.shift_enable)
            shifted = saturated >>> cfg.shift[raw_sample.channel];
        else
            shifted = saturated;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cal_valid <= 1'b0;
            cal_sample <= '0;
        end else begin
            cal_valid <= raw_valid;
            if (raw_valid) begin
                cal_sample.data <= shifted;
                cal_sample.channel <= raw_sample.channel;
            end
        end
    end

    output_held_when_idle: assert property (
        @(posedge clock) disable iff (!arst_n) !cal_valid |-> $stable(cal_sample)
    ) else $error("cal_sample changed while cal_valid was low");

endmodule

/* src/denoiser.sv */
// Per-channel dead-band stage that zeroes small samples, one cycle from input to output
`timescale 1ns/100ps

module denoiser
    import adc_pkg::*;
(
    input  logic         clock,
    input  logic         arst_n,
    input  sample_t      in_sample,
    input  logic         in_valid,
    input  denoise_cfg_t cfg,
    output sample_t      out_sample,
    output logic         out_valid
);

    data_t upper;
    data_t lower;
    logic  in_band;
    data_t cleaned;

    always_comb begin
        upper = cfg.band_high[in_sample.channel];
        lower = cfg.band_low[in_sample.channel];
        // Band edges themselves are kept
        in_band = (in_sample.data > lower) && (in_sample.data < upper);
        if (cfg.enable && in_band)
            cleaned = '0;
        else
            cleaned = in_sample.data;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;
    end

    always_ff @(posedge clock) begin
        if (in_valid) begin
            out_sample.data <= cleaned;
            out_sample.channel <= in_sample.channel;
        end
    end

endmodule

/* src/decimator.sv */
// Per-channel decimator with a single holding register, ready back-pressure and overrun flag
`timescale 1ns/100ps

module decimator
    import adc_pkg::*;
(
    input  logic                   clock,
    input  logic                   arst_n,
    input  sample_t                in_sample,
    input  logic                   in_valid,
    input  logic [ratio_width-1:0] ratio,
    input  logic                   out_ready,
    output sample_t                out_sample,
    output logic                   out_valid,
    output logic                   overrun
);

    logic [ratio_width-1:0] eff_ratio;
    logic [ratio_width-1:0] count [n_channels];
    logic [ratio_width-1:0] next_count;
    logic                   selected;
    logic                   can_load;

    always_comb begin
        // Zero acts as no decimation
        if (ratio == '0)
            eff_ratio = ratio_width'(1);
        else if (ratio > max_ratio)
            eff_ratio = ratio_width'(max_ratio);
        else
            eff_ratio = ratio;
        next_count = count[in_sample.channel] + 1'b1;
        selected = in_valid && (next_count >= eff_ratio);
    end

    // Holding register is free, or drains this cycle
    assign can_load = !out_valid || out_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < n_channels; i++)
                count[i] <= '0;
        end else if (in_valid) begin
            count[in_sample.channel] <= selected ? '0 : next_count;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            overrun <= 1'b0;
        end else begin
            overrun <= selected && !can_load;
            if (selected && can_load)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (selected && can_load)
            out_sample <= in_sample;
    end

    held_until_ready: assert property (
        @(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_sample)
    ) else $error("filtered sample changed before it was accepted");

endmodule

/* src/threshold_comparator.sv */
// High/low threshold trip detector on a sample stream, latching or following the last sample
`timescale 1ns/100ps

module threshold_comparator
    import adc_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  sample_t  in_sample,
    input  logic     in_valid,
    input  cmp_cfg_t cfg,
    output logic     trip_high,
    output logic     trip_low
);

    logic above;
    logic below;

    assign above = in_sample.data > cfg.high;
    assign below = in_sample.data < cfg.low;

    // Clear has priority over a trip seen in the same cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            trip_high <= 1'b0;
            trip_low <= 1'b0;
        end else if (cfg.clear) begin
            trip_high <= 1'b0;
            trip_low <= 1'b0;
        end else if (in_valid) begin
            if (cfg.latch) begin
                trip_high <= trip_high || above;
                trip_low <= trip_low || below;
            end else begin
                trip_high <= above;
                trip_low <= below;
            end
        end
    end

endmodule

/* src/adc_control_unit.sv */
// Configuration registers, clear pulses, registered readback and fault combining for the chain
`timescale 1ns/100ps

module adc_control_unit
    import adc_pkg::*;
(
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic                   cfg_write,
    input  logic                   cfg_read,
    input  logic [addr_width-1:0]  cfg_addr,
    input  logic [data_width-1:0]  cfg_wdata,
    input  logic [1:0]             trip_high,
    input  logic [1:0]             trip_low,
    input  logic                   overrun,
    output logic [data_width-1:0]  cfg_rdata,
    output cal_cfg_t               cal_cfg,
    output denoise_cfg_t           denoise_cfg,
    output logic [ratio_width-1:0] ratio,
    output cmp_cfg_t               fast_cmp_cfg,
    output cmp_cfg_t               slow_cmp_cfg,
    output logic                   fault
);

    // Control bits from bit 0 up are shift en, denoise en, fast latch, slow latch and sticky fault
    logic [4:0]                    control_q;
    logic [data_width-1:0]         ratio_q;
    data_t                         fast_high_q;
    data_t                         fast_low_q;
    data_t                         slow_high_q;
    data_t                         slow_low_q;
    data_t                         offset_q [n_channels];
    logic [shift_width-1:0]        shift_q [n_channels];
    data_t                         band_high_q [n_channels];
    data_t                         band_low_q [n_channels];
    logic [2:0]                    clear_q;
    logic [data_width-1:0]         rd_value;
    logic [addr_width-ch_width-1:0] addr_group;
    logic [ch_width-1:0]           addr_ch;
    logic                          fault_event;

    assign addr_group = cfg_addr[addr_width-1:ch_width];
    assign addr_ch = cfg_addr[ch_width-1:0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            control_q <= '0;
            ratio_q <= '0;
            fast_high_q <= '0;
            fast_low_q <= '0;
            slow_high_q <= '0;
            slow_low_q <= '0;
            for (int i = 0; i < n_channels; i++) begin
                offset_q[i] <= '0;
                shift_q[i] <= '0;
                band_high_q[i] <= '0;
                band_low_q[i] <= '0;
            end
        end else if (cfg_write) begin
            case (cfg_addr)
                reg_control:   control_q <= cfg_wdata[4:0];
                reg_ratio:     ratio_q <= cfg_wdata;
                reg_fast_high: fast_high_q <= cfg_wdata;
                reg_fast_low:  fast_low_q <= cfg_wdata;
                reg_slow_high: slow_high_q <= cfg_wdata;
                reg_slow_low:  slow_low_q <= cfg_wdata;
                default: begin
                    // Per-channel banks
                    if (addr_group == reg_offset_base[addr_width-1:ch_width])
                        offset_q[addr_ch] <= cfg_wdata;
                    else if (addr_group == reg_shift_base[addr_width-1:ch_width])
                        shift_q[addr_ch] <= cfg_wdata[shift_width-1:0];
                    else if (addr_group == reg_band_high_base[addr_width-1:ch_width])
                        band_high_q[addr_ch] <= cfg_wdata;
                    else if (addr_group == reg_band_low_base[addr_width-1:ch_width])
                        band_low_q[addr_ch] <= cfg_wdata;
                end
            endcase
        end
    end

    // One-cycle clear strobes from reg_clear writes
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            clear_q <= '0;
        else if (cfg_write && cfg_addr == reg_clear)
            clear_q <= cfg_wdata[2:0];
        else
            clear_q <= '0;
    end

    always_comb begin
        rd_value = '0;
        case (cfg_addr)
            reg_control:   rd_value = data_width'(control_q);
            reg_ratio:     rd_value = ratio_q;
            reg_fast_high: rd_value = fast_high_q;
            reg_fast_low:  rd_value = fast_low_q;
            reg_slow_high: rd_value = slow_high_q;
            reg_slow_low:  rd_value = slow_low_q;
            default: begin
                if (addr_group == reg_offset_base[addr_width-1:ch_width])
                    rd_value = offset_q[addr_ch];
                else if (addr_group == reg_shift_base[addr_width-1:ch_width])
                    rd_value = data_width'(shift_q[addr_ch]);
                else if (addr_group == reg_band_high_base[addr_width-1:ch_width])
                    rd_value = band_high_q[addr_ch];
                else if (addr_group == reg_band_low_base[addr_width-1:ch_width])
                    rd_value = band_low_q[addr_ch];
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            cfg_rdata <= '0;
        else if (cfg_read)
            cfg_rdata <= rd_value;
    end

    assign fault_event = (|trip_high) || (|trip_low) || overrun;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            fault <= 1'b0;
        else if (control_q[4])
            fault <= fault_event || (fault && !clear_q[2]);
        else
            fault <= fault_event;
    end

    // Ratio register saturates at the decimator limit
    assign ratio = (ratio_q > max_ratio) ? ratio_width'(max_ratio) : ratio_q[ratio_width-1:0];

    always_comb begin
        cal_cfg.shift_enable = control_q[0];
        denoise_cfg.enable = control_q[1];
        for (int i = 0; i < n_channels; i++) begin
            cal_cfg.offset[i] = offset_q[i];
            cal_cfg.shift[i] = shift_q[i];
            denoise_cfg.band_high[i] = band_high_q[i];
            denoise_cfg.band_low[i] = band_low_q[i];
        end
        fast_cmp_cfg.high = fast_high_q;
        fast_cmp_cfg.low = fast_low_q;
        fast_cmp_cfg.latch = control_q[2];
        fast_cmp_cfg.clear = clear_q[0];
        slow_cmp_cfg.high = slow_high_q;
        slow_cmp_cfg.low = slow_low_q;
        slow_cmp_cfg.latch = control_q[3];
        slow_cmp_cfg.clear = clear_q[1];
    end

    clear_single_cycle: assert property (
        @(posedge clock) disable iff (!arst_n) (clear_q & $past(clear_q)) == 3'b000
    ) else $error("clear pulse lasted more than one cycle");

endmodule

/* src/adc_processing.sv */
// Top level of the ADC conditioning subsystem, wires control unit, datapath and comparators
`timescale 1ns/100ps

module adc_processing
    import adc_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  sample_t               raw_sample,
    input  logic                  raw_valid,
    input  logic                  cfg_write,
    input  logic                  cfg_read,
    input  logic [addr_width-1:0] cfg_addr,
    input  logic [data_width-1:0] cfg_wdata,
    output logic [data_width-1:0] cfg_rdata,
    output sample_t               fast_sample,
    output logic                  fast_valid,
    output sample_t               filt_sample,
    output logic                  filt_valid,
    input  logic                  filt_ready,
    output logic [1:0]            trip_high,
    output logic [1:0]            trip_low,
    output logic                  fault
);

    cal_cfg_t               cal_cfg;
    denoise_cfg_t           denoise_cfg;
    cmp_cfg_t               fast_cmp_cfg;
    cmp_cfg_t               slow_cmp_cfg;
    logic [ratio_width-1:0] ratio;
    logic                   overrun;
    sample_t                cal_sample;
    logic                   cal_valid;
    logic                   filt_accept;

    // Slow comparator only sees samples taken by the consumer
    assign filt_accept = filt_valid && filt_ready;

    adc_control_unit control_unit_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .cfg_write    (cfg_write),
        .cfg_read     (cfg_read),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .trip_high    (trip_high),
        .trip_low     (trip_low),
        .overrun      (overrun),
        .cfg_rdata    (cfg_rdata),
        .cal_cfg      (cal_cfg),
        .denoise_cfg  (denoise_cfg),
        .ratio        (ratio),
        .fast_cmp_cfg (fast_cmp_cfg),
        .slow_cmp_cfg (slow_cmp_cfg),
        .fault        (fault)
    );

    calibration calibration_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .raw_sample (raw_sample),
        .raw_valid  (raw_valid),
        .cfg        (cal_cfg),
        .cal_sample (cal_sample),
        .cal_valid  (cal_valid)
    );

    denoiser denoiser_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_sample  (cal_sample),
        .in_valid   (cal_valid),
        .cfg        (denoise_cfg),
        .out_sample (fast_sample),
        .out_valid  (fast_valid)
    );

    decimator decimator_i (
        .clock      (clock),
        .arst_n     (arst_n),
        .in_sample  (fast_sample),
        .in_valid   (fast_valid),
        .ratio      (ratio),
        .out_ready  (filt_ready),
        .out_sample (filt_sample),
        .out_valid  (filt_valid),
        .overrun    (overrun)
    );

    threshold_comparator fast_cmp_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_sample (fast_sample),
        .in_valid  (fast_valid),
        .cfg       (fast_cmp_cfg),
        .trip_high (trip_high[0]),
        .trip_low  (trip_low[0])
    );

    threshold_comparator slow_cmp_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_sample (filt_sample),
        .in_valid  (filt_accept),
        .cfg       (slow_cmp_cfg),
        .trip_high (trip_high[1]),
        .trip_low  (trip_low[1])
    );

endmodule

/* tb/adc_processing_tb.sv */
// Self-checking testbench for adc_processing, run as the simulation top with the file list
`timescale 1ns/100ps

module adc_processing_tb
    import adc_pkg::*;
();

    typedef struct packed {
        sample_t s;
        logic    drop;
    } fast_entry_t;

    // Expected flag state for one cycle
    typedef struct packed {
        logic [1:0] high;
        logic [1:0] low;
        logic       overrun;
        logic       fault;
    } flags_t;

    // Rough cycle budget for reset and then each test in order
    localparam int planned_cycles = 10 + 50 + 130 + 90 + 365 + 30 + 60;
    localparam int cycle_limit = planned_cycles * 3 / 2;
    localparam int max_value = 2 ** (data_width - 1) - 1;

    logic                  clock;
    logic                  arst_n;
    sample_t               raw_sample;
    logic                  raw_valid;
    logic                  cfg_write;
    logic                  cfg_read;
    logic [addr_width-1:0] cfg_addr;
    logic [data_width-1:0] cfg_wdata;
    logic [data_width-1:0] cfg_rdata;
    sample_t               fast_sample;
    logic                  fast_valid;
    sample_t               filt_sample;
    logic                  filt_valid;
    logic                  filt_ready;
    logic [1:0]            trip_high;
    logic [1:0]            trip_low;
    logic                  fault;

    logic [15:0]     lfsr_state = 16'd39;
    logic            raw_drop = 1'b0;
    logic [15:0]     shadow [32] = '{default: '0};
    int              count_model [n_channels] = '{default: 0};
    fast_entry_t     fast_q [$];
    sample_t         filt_q [$];
    sample_t         fast_exp = '0;
    sample_t         filt_exp = '0;
    logic            fast_v_exp = 1'b0;
    logic            v_d1 = 1'b0;
    logic            v_d2 = 1'b0;
    logic            filt_extra = 1'b0;
    flags_t          flags_cur = '0;
    flags_t          flags_next = '0;
    logic [2:0]      clr_now = '0;
    logic [2:0]      clr_pend = '0;
    logic [15:0]     rd_cur = '0;
    logic [15:0]     rd_next = '0;
    int              errors = 0;
    int              errors_before = 0;
    int              tests_done = 0;
    int              cycles = 0;

    adc_processing dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit returned
    function automatic logic [15:0] random_bits(input int width);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
            value = {value[14:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Offset, saturate, shift and then dead band from the written registers
    function automatic data_t conditioned(input sample_t raw);
        int value;
        int ch;
        ch = raw.channel;
        value = int'(raw.data) + int'($signed(shadow[reg_offset_base + ch]));
        if (value > max_value)
            value = max_value;
        else if (value < -max_value - 1)
            value = -max_value - 1;
        if (shadow[reg_control][0])
            value = value >>> shadow[reg_shift_base + ch][2:0];
        if (shadow[reg_control][1] && value > $signed(shadow[reg_band_low_base + ch])
                && value < $signed(shadow[reg_band_high_base + ch]))
            value = 0;
        return data_t'(value);
    endfunction

    function automatic logic decimate_select(input int ch);
        int ratio_eff;
        ratio_eff = shadow[reg_ratio];
        if (ratio_eff == 0)
            ratio_eff = 1;
        else if (ratio_eff > max_ratio)
            ratio_eff = max_ratio;
        count_model[ch]++;
        if (count_model[ch] >= ratio_eff) begin
            count_model[ch] = 0;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // Reference model evaluated mid-cycle where all signals are settled
    always @(negedge clock) begin : reference_model
        fast_entry_t entry;
        logic [1:0]  seen;
        logic [1:0]  above;
        logic [1:0]  below;
        logic [1:0]  latch;
        logic        event_seen;
        flags_cur = flags_next;
        rd_cur = rd_next;
        clr_now = clr_pend;
        clr_pend = (cfg_write && cfg_addr == reg_clear) ? cfg_wdata[2:0] : 3'b000;
        fast_v_exp = v_d2;
        v_d2 = v_d1;
        v_d1 = raw_valid;
        seen = 2'b00;
        flags_next.overrun = 1'b0;
        filt_extra = 1'b0;
        if (fast_v_exp) begin
            entry = fast_q.pop_front();
            fast_exp = entry.s;
            seen[0] = 1'b1;
            flags_next.overrun = entry.drop;
        end
        if (filt_valid) begin
            if (filt_q.size() > 0)
                filt_exp = filt_q[0];
            else
                filt_extra = 1'b1;
            if (filt_ready && filt_q.size() > 0) begin
                seen[1] = 1'b1;
                void'(filt_q.pop_front());
            end
        end
        above[0] = fast_exp.data > $signed(shadow[reg_fast_high]);
        below[0] = fast_exp.data < $signed(shadow[reg_fast_low]);
        above[1] = filt_exp.data > $signed(shadow[reg_slow_high]);
        below[1] = filt_exp.data < $signed(shadow[reg_slow_low]);
        latch = shadow[reg_control][3:2];
        for (int i = 0; i < 2; i++) begin
            if (clr_now[i]) begin
                flags_next.high[i] = 1'b0;
                flags_next.low[i] = 1'b0;
            end else if (seen[i]) begin
                flags_next.high[i] = above[i] || (latch[i] && flags_cur.high[i]);
                flags_next.low[i] = below[i] || (latch[i] && flags_cur.low[i]);
            end
        end
        event_seen = (|flags_cur.high) || (|flags_cur.low) || flags_cur.overrun;
        if (shadow[reg_control][4])
            flags_next.fault = event_seen || (flags_cur.fault && !clr_now[2]);
        else
            flags_next.fault = event_seen;
        if (cfg_read)
            rd_next = shadow[cfg_addr];
        if (raw_valid) begin
            entry.s.channel = raw_sample.channel;
            entry.s.data = conditioned(raw_sample);
            entry.drop = raw_drop;
            fast_q.push_back(entry);
            if (decimate_select(raw_sample.channel) && !raw_drop)
                filt_q.push_back(entry.s);
        end
        // Register writes land at the next edge
        if (cfg_write && cfg_addr != reg_clear)
            shadow[cfg_addr] = cfg_wdata;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
    endtask

    fast_valid_check: assert property (@(posedge clock) disable iff (!arst_n)
        fast_valid == fast_v_exp)
        else report_mismatch("fast_valid", fast_v_exp, $sampled(fast_valid));
    fast_sample_check: assert property (@(posedge clock) disable iff (!arst_n)
        fast_v_exp |-> fast_sample == fast_exp)
        else report_mismatch("fast_sample", fast_exp, $sampled(fast_sample));
    filt_sample_check: assert property (@(posedge clock) disable iff (!arst_n)
        filt_valid && !filt_extra |-> filt_sample == filt_exp)
        else report_mismatch("filt_sample", filt_exp, $sampled(filt_sample));
    filt_extra_check: assert property (@(posedge clock) disable iff (!arst_n) !filt_extra)
    else begin
        errors++;
        $display("Filtered output presented a sample that no rule selected at %0t", $time);
    end
    rdata_check: assert property (@(posedge clock) disable iff (!arst_n) cfg_rdata == rd_cur)
        else report_mismatch("cfg_rdata", rd_cur, $sampled(cfg_rdata));
    trip_check: assert property (@(posedge clock) disable iff (!arst_n)
        {trip_high, trip_low} == {flags_cur.high, flags_cur.low})
        else report_mismatch("trip_high/trip_low", {flags_cur.high, flags_cur.low},
                             $sampled({trip_high, trip_low}));
    fault_check: assert property (@(posedge clock) disable iff (!arst_n)
        fault == flags_cur.fault)
        else report_mismatch("fault", flags_cur.fault, $sampled(fault));

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic write_reg(input logic [addr_width-1:0] addr, input logic [15:0] data);
        cfg_write = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        next_cycle();
        cfg_write = 1'b0;
    endtask

    task automatic read_reg(input logic [addr_width-1:0] addr);
        cfg_read = 1'b1;
        cfg_addr = addr;
        next_cycle();
        cfg_read = 1'b0;
    endtask

    task automatic send_sample(input logic [15:0] data, input logic [1:0] channel,
                               input logic drop);
        raw_valid = 1'b1;
        raw_sample.data = data;
        raw_sample.channel = channel;
        raw_drop = drop;
        next_cycle();
        raw_valid = 1'b0;
        raw_drop = 1'b0;
    endtask

    // Wait until every expected sample has come out, then let the flags settle
    task automatic wait_drain();
        while (fast_q.size() != 0 || filt_q.size() != 0)
            next_cycle();
        repeat (2) next_cycle();
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("%s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    initial begin
        int ratios [3] = '{1, 3, 16};
        int levels [6] = '{1500, 0, -1500, 2500, -2500, 0};
        int bound;
        arst_n = 1'b0;
        raw_sample = '0;
        raw_valid = 1'b0;
        cfg_write = 1'b0;
        cfg_read = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        filt_ready = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        arst_n = 1'b1;

        for (int a = 0; a < 24; a++) begin
            if (a != reg_clear && a != 3)
                write_reg(a, random_bits(16) & (a == reg_control ? 16'h001f :
                          (a >= reg_shift_base && a < reg_shift_base + 4) ? 16'h0007 : 16'hffff));
        end
        write_reg(reg_clear, 16'h0007);
        for (int a = 0; a < 24; a++)
            read_reg(a);
        next_cycle();
        finish_test("register readback");

        write_reg(reg_control, 16'h0000);
        write_reg(reg_ratio, 16'd1);
        // Thresholds at the range limits never trip
        write_reg(reg_fast_high, 16'h7fff);
        write_reg(reg_fast_low, 16'h8000);
        write_reg(reg_slow_high, 16'h7fff);
        write_reg(reg_slow_low, 16'h8000);
        write_reg(reg_offset_base, 16'h7000);
        write_reg(reg_offset_base + 1, 16'h9000);
        write_reg(reg_offset_base + 2, random_bits(16));
        write_reg(reg_offset_base + 3, random_bits(16));
        for (int c = 0; c < n_channels; c++)
            write_reg(reg_shift_base + c, random_bits(3));
        for (int pass = 0; pass < 2; pass++) begin
            write_reg(reg_control, pass);
            send_sample(16'h7fff, 2'd0, 1'b0);
            send_sample(16'h8000, 2'd1, 1'b0);
            repeat (48) send_sample(random_bits(16), random_bits(2), 1'b0);
            wait_drain();
        end
        finish_test("calibration");

        write_reg(reg_control, 16'h0002);
        for (int c = 0; c < n_channels; c++) begin
            write_reg(reg_offset_base + c, 16'h0000);
            bound = random_bits(8) + 1;
            write_reg(reg_band_high_base + c, bound);
            write_reg(reg_band_low_base + c, -bound);
        end
        for (int c = 0; c < n_channels; c++) begin
            send_sample(shadow[reg_band_high_base + c], c, 1'b0);
            send_sample(shadow[reg_band_low_base + c], c, 1'b0);
            send_sample(shadow[reg_band_high_base + c] - 1, c, 1'b0);
            send_sample(shadow[reg_band_low_base + c] + 1, c, 1'b0);
        end
        repeat (32) send_sample(random_bits(10) - 512, random_bits(2), 1'b0);
        write_reg(reg_control, 16'h0000);
        repeat (16) send_sample(random_bits(10) - 512, random_bits(2), 1'b0);
        wait_drain();
        finish_test("dead band");

        foreach (ratios[r]) begin
            write_reg(reg_ratio, ratios[r]);
            repeat (16 * ratios[r] + 8) send_sample(random_bits(16), random_bits(2), 1'b0);
            wait_drain();
        end
        finish_test("decimation");

        write_reg(reg_ratio, 16'd1);
        filt_ready = 1'b0;
        send_sample(16'h1234, 2'd0, 1'b0);
        while (!filt_valid)
            next_cycle();
        repeat (3) next_cycle();
        // Holding register is full, so these two are lost
        send_sample(16'h2345, 2'd1, 1'b1);
        send_sample(16'h3456, 2'd2, 1'b1);
        while (!fault)
            next_cycle();
        filt_ready = 1'b1;
        send_sample(16'h4567, 2'd3, 1'b0);
        send_sample(16'h5678, 2'd0, 1'b0);
        wait_drain();
        finish_test("back-pressure and overrun");

        write_reg(reg_fast_high, 16'd1000);
        write_reg(reg_fast_low, -16'sd1000);
        write_reg(reg_slow_high, 16'd2000);
        write_reg(reg_slow_low, -16'sd2000);
        // Following, then latching on both comparators, then sticky fault
        foreach (levels[i])
            send_sample(levels[i], i % 4, 1'b0);
        wait_drain();
        write_reg(reg_control, 16'h000c);
        for (int i = 2; i < 6; i++)
            send_sample(levels[i], i % 4, 1'b0);
        wait_drain();
        write_reg(reg_clear, 16'h0003);
        wait_drain();
        write_reg(reg_control, 16'h0010);
        send_sample(16'd1500, 2'd1, 1'b0);
        send_sample(16'd0, 2'd1, 1'b0);
        wait_drain();
        write_reg(reg_clear, 16'h0004);
        wait_drain();
        finish_test("comparators and fault");

        $display("%0d tests run, %0d checks failed", tests_done, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* adc_processing.f */
src/adc_pkg.sv
src/calibration.sv
src/denoiser.sv
src/decimator.sv
src/threshold_comparator.sv
src/adc_control_unit.sv
src/adc_processing.sv
tb/adc_processing_tb.sv

/* Bender.yml */
package:
  name: adc_processing

sources:
  - src/adc_pkg.sv
  - src/calibration.sv
  - src/denoiser.sv
  - src/decimator.sv
  - src/threshold_comparator.sv
  - src/adc_control_unit.sv
  - src/adc_processing.sv
  - target: test
    files:
      - tb/adc_processing_tb.sv
